//--- src.f
verilog/periph_xbar_pkg.sv
verilog/xbar_req_if.sv
verilog/periph_addr_decode.sv
verilog/periph_rr_arbiter.sv
verilog/periph_resp_router.sv
verilog/periph_xbar.sv
bench/periph_xbar_properties.sv
bench/periph_xbar_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module periph_xbar_tb -f src.f -o periph_xbar_sim
./obj_dir/periph_xbar_sim

//--- bench/periph_xbar_tb.sv
`default_nettype none

module periph_xbar_tb;

  logic                                                   clk_i;
  logic                                                   rst_n_i;
  periph_xbar_pkg::cluster_id_t                           cluster_id_i;
  logic [periph_xbar_pkg::N_INPS-1:0]                     in_req_i;
  periph_xbar_pkg::addr_t   [periph_xbar_pkg::N_INPS-1:0] in_addr_i;
  periph_xbar_pkg::data_t   [periph_xbar_pkg::N_INPS-1:0] in_wdata_i;
  logic [periph_xbar_pkg::N_INPS-1:0]                     in_wen_i;
  periph_xbar_pkg::be_t     [periph_xbar_pkg::N_INPS-1:0] in_be_i;
  logic [periph_xbar_pkg::N_INPS-1:0]                     in_gnt_o;
  logic [periph_xbar_pkg::N_INPS-1:0]                     in_r_valid_o;
  periph_xbar_pkg::data_t   [periph_xbar_pkg::N_INPS-1:0] in_r_rdata_o;
  logic [periph_xbar_pkg::N_INPS-1:0]                     in_r_opc_o;
  logic [periph_xbar_pkg::N_OUPS-1:0]                     out_req_o;
  periph_xbar_pkg::addr_t   [periph_xbar_pkg::N_OUPS-1:0] out_addr_o;
  periph_xbar_pkg::data_t   [periph_xbar_pkg::N_OUPS-1:0] out_wdata_o;
  logic [periph_xbar_pkg::N_OUPS-1:0]                     out_wen_o;
  periph_xbar_pkg::be_t     [periph_xbar_pkg::N_OUPS-1:0] out_be_o;
  periph_xbar_pkg::inp_id_t [periph_xbar_pkg::N_OUPS-1:0] out_id_o;
  logic [periph_xbar_pkg::N_OUPS-1:0]                     out_gnt_i;
  logic [periph_xbar_pkg::N_OUPS-1:0]                     out_r_valid_i;
  periph_xbar_pkg::data_t   [periph_xbar_pkg::N_OUPS-1:0] out_r_rdata_i;
  periph_xbar_pkg::inp_id_t [periph_xbar_pkg::N_OUPS-1:0] out_r_id_i;
  logic [periph_xbar_pkg::N_OUPS-1:0]                     out_r_opc_i;
  logic [31:0]                                            rng_state;

  // decode rows, one initiator each, expected target worked out from the address map
  string row_name [7] = '{"local_t1", "local_t2", "mperiph_t0", "outside_map",
    "local_not_periph", "other_cluster_core", "other_cluster_mperiph"};
  periph_xbar_pkg::cluster_id_t row_cid [7] = '{6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd1, 6'd1};
  int unsigned row_inp [7] = '{0, 1, 2, 0, 1, 0, 2};
  periph_xbar_pkg::addr_t row_addr [7] = '{32'h1021_0040, 32'h1032_0008, 32'h1020_0010,
    32'h1A00_0000, 32'h1013_0000, 32'h1021_0000, 32'h1021_0000};
  logic [3:0] row_gnt [7] = '{4'hF, 4'b0100, 4'hF, 4'b1000, 4'hF, 4'hF, 4'b0010};
  periph_xbar_pkg::oup_idx_t row_idx [7] = '{2'd1, 2'd2, 2'd0, 2'd3, 2'd3, 2'd3, 2'd1};
  // grant order with all three contending for target 2, initiator 0 asks twice
  int unsigned rr_seq [4] = '{0, 1, 2, 0};

  periph_xbar dut0 (.*);

  bind periph_xbar periph_xbar_properties props0 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .in_req_i  (in_req_i),
    .in_gnt_i  (in_gnt_o),
    .out_req_i (out_req_o),
    .out_id_i  (out_id_o),
    .out_gnt_i (out_gnt_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  task automatic next_rand(output periph_xbar_pkg::data_t v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  task automatic stop_on_error(input string msg);
    $display("*** FAILED ***");
    $fatal(1, "%s", msg);
  endtask

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
    stop_on_error("a DUT output differs from its expected value");
  endtask

  task automatic check_idx(input string name, input periph_xbar_pkg::oup_idx_t exp,
                           input periph_xbar_pkg::oup_idx_t act);
    if (act !== exp) mismatch(name, 32'(exp), 32'(act));
  endtask

  task automatic check_id(input string name, input periph_xbar_pkg::inp_id_t exp,
                          input periph_xbar_pkg::inp_id_t act);
    if (act !== exp) mismatch(name, 32'(exp), 32'(act));
  endtask

  task automatic check_data(input string name, input periph_xbar_pkg::data_t exp,
                            input periph_xbar_pkg::data_t act);
    if (act !== exp) mismatch(name, exp, act);
  endtask

  task automatic check_be(input string name, input periph_xbar_pkg::be_t exp,
                          input periph_xbar_pkg::be_t act);
    if (act !== exp) mismatch(name, 32'(exp), 32'(act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) mismatch(name, 32'(exp), 32'(act));
  endtask

  // index of the raised target request, zero when none
  function automatic periph_xbar_pkg::oup_idx_t req_to_idx(
    input logic [periph_xbar_pkg::N_OUPS-1:0] req
  );
    periph_xbar_pkg::oup_idx_t idx;
    idx = '0;
    for (int j = 0; j < periph_xbar_pkg::N_OUPS; j++) begin
      if (req[j]) begin
        idx = periph_xbar_pkg::oup_idx_t'(j);
      end
    end
    return idx;
  endfunction

  task automatic drive_idle();
    in_req_i      = '0;
    in_addr_i     = '0;
    in_wdata_i    = '0;
    in_wen_i      = '0;
    in_be_i       = '0;
    out_gnt_i     = '0;
    out_r_valid_i = '0;
    out_r_rdata_i = '0;
    out_r_id_i    = '0;
    out_r_opc_i   = '0;
  endtask

  // inputs change shortly after the rising edge, outputs are sampled 40 later
  task automatic next_drive_slot();
    @(posedge clk_i);
    #10;
  endtask

  task automatic apply_reset();
    drive_idle();
    cluster_id_i = '0;
    rst_n_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
  endtask

  task automatic wait_for_grant(input int unsigned k);
    int unsigned n;
    n = 0;
    #40;
    while (!in_gnt_o[k]) begin
      n++;
      if (n > 20) begin
        stop_on_error("timeout while waiting for a grant to an initiator");
      end else begin
        next_drive_slot();
        #40;
      end
    end
  endtask

  task automatic run_decode_row(input int unsigned r);
    periph_xbar_pkg::data_t    wd;
    periph_xbar_pkg::oup_idx_t idx;
    int unsigned               k;
    idx = row_idx[r];
    k = row_inp[r];
    next_rand(wd);
    next_drive_slot();
    drive_idle();
    cluster_id_i  = row_cid[r];
    in_req_i[k]   = 1'b1;
    in_addr_i[k]  = row_addr[r];
    in_wdata_i[k] = wd;
    in_wen_i[k]   = wd[0];
    in_be_i[k]    = wd[7:4];
    out_gnt_i     = row_gnt[r];
    #40;
    check_bit(row_name[r], 1'b1, $onehot(out_req_o));
    check_idx(row_name[r], idx, req_to_idx(out_req_o));
    check_data(row_name[r], row_addr[r], out_addr_o[idx]);
    check_data(row_name[r], wd, out_wdata_o[idx]);
    check_bit(row_name[r], wd[0], out_wen_o[idx]);
    check_be(row_name[r], wd[7:4], out_be_o[idx]);
    check_id(row_name[r], periph_xbar_pkg::inp_id_t'(1 << k), out_id_o[idx]);
    check_bit(row_name[r], 1'b1, in_gnt_o[k]);
  endtask

  task automatic run_round_robin();
    int unsigned            pending [periph_xbar_pkg::N_INPS];
    periph_xbar_pkg::data_t wd [periph_xbar_pkg::N_INPS];
    pending = '{2, 1, 1};
    foreach (wd[i]) begin
      next_rand(wd[i]);
    end
    foreach (rr_seq[c]) begin
      next_drive_slot();
      out_gnt_i = 4'hF;
      for (int i = 0; i < periph_xbar_pkg::N_INPS; i++) begin
        in_req_i[i]   = (pending[i] != 0);
        in_addr_i[i]  = 32'h1022_0000;
        in_wdata_i[i] = wd[i];
      end
      #40;
      check_id("round_robin_gnt", periph_xbar_pkg::inp_id_t'(1 << rr_seq[c]), in_gnt_o);
      check_data("round_robin_wdata", wd[rr_seq[c]], out_wdata_o[2]);
      // a granted initiator drops its request or moves on to fresh data
      for (int i = 0; i < periph_xbar_pkg::N_INPS; i++) begin
        if (in_gnt_o[i]) begin
          pending[i]--;
          next_rand(wd[i]);
        end
      end
    end
  endtask

  task automatic run_back_pressure();
    periph_xbar_pkg::data_t wd1;
    periph_xbar_pkg::data_t wd2;
    next_rand(wd1);
    next_rand(wd2);
    next_drive_slot();
    drive_idle();
    in_req_i      = 3'b110;
    in_addr_i[1]  = 32'h1021_0000;
    in_addr_i[2]  = 32'h1021_0000;
    in_wdata_i[1] = wd1;
    in_wdata_i[2] = wd2;
    // target 1 pointer is at 0 after reset, so initiator 1 leads
    repeat (3) begin
      #40;
      check_bit("stall_req", 1'b1, out_req_o[1]);
      check_data("stall_addr", 32'h1021_0000, out_addr_o[1]);
      check_data("stall_wdata", wd1, out_wdata_o[1]);
      check_id("stall_gnt", '0, in_gnt_o);
      next_drive_slot();
    end
    out_gnt_i = 4'b0010;
    wait_for_grant(1);
    check_id("stall_winner", 3'b010, in_gnt_o);
    next_drive_slot();
    in_req_i[1] = 1'b0;
    wait_for_grant(2);
    check_id("stall_next_id", 3'b100, out_id_o[1]);
    check_data("stall_next_wdata", wd2, out_wdata_o[1]);
  endtask

  task automatic run_responses();
    periph_xbar_pkg::data_t rd_a;
    periph_xbar_pkg::data_t rd_b;
    int unsigned            ib;
    int unsigned            jb;
    string                  name;
    for (int unsigned j = 0; j < periph_xbar_pkg::N_OUPS; j++) begin
      for (int unsigned i = 0; i < periph_xbar_pkg::N_INPS; i++) begin
        // a second target answers the next initiator in the same cycle
        ib = (i + 1) % periph_xbar_pkg::N_INPS;
        jb = (j + 1) % periph_xbar_pkg::N_OUPS;
        name = $sformatf("resp_t%0d_i%0d", j, i);
        next_rand(rd_a);
        next_rand(rd_b);
        next_drive_slot();
        drive_idle();
        out_r_valid_i[j]  = 1'b1;
        out_r_id_i[j]     = periph_xbar_pkg::inp_id_t'(1 << i);
        out_r_rdata_i[j]  = rd_a;
        out_r_opc_i[j]    = rd_a[0];
        out_r_valid_i[jb] = 1'b1;
        out_r_id_i[jb]    = periph_xbar_pkg::inp_id_t'(1 << ib);
        out_r_rdata_i[jb] = rd_b;
        out_r_opc_i[jb]   = rd_b[0];
        #40;
        check_id(name, periph_xbar_pkg::inp_id_t'((1 << i) | (1 << ib)), in_r_valid_o);
        check_data(name, rd_a, in_r_rdata_o[i]);
        check_bit(name, rd_a[0], in_r_opc_o[i]);
        check_data(name, rd_b, in_r_rdata_o[ib]);
        check_bit(name, rd_b[0], in_r_opc_o[ib]);
      end
    end
  endtask

  initial begin
    rng_state = 32'h400d9bc6;
    apply_reset();
    #40;
    check_id("idle_gnt", '0, in_gnt_o);
    check_id("idle_r_valid", '0, in_r_valid_o);
    check_bit("idle_out_req", 1'b0, |out_req_o);
    foreach (row_name[r]) begin
      run_decode_row(r);
    end
    // fresh pointers so the grant order starts at initiator 0
    next_drive_slot();
    apply_reset();
    run_round_robin();
    run_back_pressure();
    run_responses();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/periph_xbar_properties.sv
`default_nettype none

module periph_xbar_properties (
  input wire logic                                                   clk_i,
  input wire logic                                                   rst_n_i,
  input wire logic [periph_xbar_pkg::N_INPS-1:0]                     in_req_i,
  input wire logic [periph_xbar_pkg::N_INPS-1:0]                     in_gnt_i,
  input wire logic [periph_xbar_pkg::N_OUPS-1:0]                     out_req_i,
  input wire periph_xbar_pkg::inp_id_t [periph_xbar_pkg::N_OUPS-1:0] out_id_i,
  input wire logic [periph_xbar_pkg::N_OUPS-1:0]                     out_gnt_i
);

  // an initiator is only granted what it asked for
  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (in_gnt_i & ~in_req_i) == '0)
    else $error("grant seen on an initiator that is not requesting");

  // a target request always has some initiator behind it
  req_has_source: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|out_req_i) |-> (|in_req_i))
    else $error("target request without any initiator request");

  // every accepting target hands its grant to exactly one initiator
  single_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $countones(in_gnt_i) == $countones(out_req_i & out_gnt_i))
    else $error("grants to initiators do not match the accepting targets");

  for (genvar j = 0; j < periph_xbar_pkg::N_OUPS; j++) begin : gen_oup
    id_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_req_i[j] |-> $onehot(out_id_i[j]))
      else $error("target %0d carries an id that is not one-hot", j);
  end

endmodule

`default_nettype wire

//--- verilog/periph_xbar.sv
`default_nettype none

module periph_xbar (
  input  wire logic                                                   clk_i,
  input  wire logic                                                   rst_n_i,
  input  wire periph_xbar_pkg::cluster_id_t                           cluster_id_i,

  // initiator request side
  input  wire logic [periph_xbar_pkg::N_INPS-1:0]                     in_req_i,
  input  wire periph_xbar_pkg::addr_t   [periph_xbar_pkg::N_INPS-1:0] in_addr_i,
  input  wire periph_xbar_pkg::data_t   [periph_xbar_pkg::N_INPS-1:0] in_wdata_i,
  input  wire logic [periph_xbar_pkg::N_INPS-1:0]                     in_wen_i,
  input  wire periph_xbar_pkg::be_t     [periph_xbar_pkg::N_INPS-1:0] in_be_i,
  output logic [periph_xbar_pkg::N_INPS-1:0]                          in_gnt_o,

  // initiator response side
  output logic [periph_xbar_pkg::N_INPS-1:0]                          in_r_valid_o,
  output periph_xbar_pkg::data_t [periph_xbar_pkg::N_INPS-1:0]        in_r_rdata_o,
  output logic [periph_xbar_pkg::N_INPS-1:0]                          in_r_opc_o,

  // target request side
  output logic [periph_xbar_pkg::N_OUPS-1:0]                          out_req_o,
  output periph_xbar_pkg::addr_t   [periph_xbar_pkg::N_OUPS-1:0]      out_addr_o,
  output periph_xbar_pkg::data_t   [periph_xbar_pkg::N_OUPS-1:0]      out_wdata_o,
  output logic [periph_xbar_pkg::N_OUPS-1:0]                          out_wen_o,
  output periph_xbar_pkg::be_t     [periph_xbar_pkg::N_OUPS-1:0]      out_be_o,
  output periph_xbar_pkg::inp_id_t [periph_xbar_pkg::N_OUPS-1:0]      out_id_o,
  input  wire logic [periph_xbar_pkg::N_OUPS-1:0]                     out_gnt_i,

  // target response side
  input  wire logic [periph_xbar_pkg::N_OUPS-1:0]                     out_r_valid_i,
  input  wire periph_xbar_pkg::data_t   [periph_xbar_pkg::N_OUPS-1:0] out_r_rdata_i,
  input  wire periph_xbar_pkg::inp_id_t [periph_xbar_pkg::N_OUPS-1:0] out_r_id_i,
  input  wire logic [periph_xbar_pkg::N_OUPS-1:0]                     out_r_opc_i
);

  // decoded requests from the decode stage to the per-target arbiters
  xbar_req_if req_bus ();

  periph_addr_decode i_decode (
    .cluster_id_i (cluster_id_i),
    .in_req_i     (in_req_i),
    .in_addr_i    (in_addr_i),
    .in_wdata_i   (in_wdata_i),
    .in_wen_i     (in_wen_i),
    .in_be_i      (in_be_i),
    .in_gnt_o     (in_gnt_o),
    .req_bus      (req_bus.decode)
  );

  periph_rr_arbiter i_arb (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_bus     (req_bus.arbiter),
    .out_req_o   (out_req_o),
    .out_addr_o  (out_addr_o),
    .out_wdata_o (out_wdata_o),
    .out_wen_o   (out_wen_o),
    .out_be_o    (out_be_o),
    .out_id_o    (out_id_o),
    .out_gnt_i   (out_gnt_i)
  );

  // responses bypass the arbiters, steered by id alone
  periph_resp_router i_resp (
    .out_r_valid_i (out_r_valid_i),
    .out_r_rdata_i (out_r_rdata_i),
    .out_r_id_i    (out_r_id_i),
    .out_r_opc_i   (out_r_opc_i),
    .in_r_valid_o  (in_r_valid_o),
    .in_r_rdata_o  (in_r_rdata_o),
    .in_r_opc_o    (in_r_opc_o)
  );

endmodule

`default_nettype wire

//--- verilog/periph_resp_router.sv
`default_nettype none

module periph_resp_router (
  input  wire logic [periph_xbar_pkg::N_OUPS-1:0]                     out_r_valid_i,
  input  wire periph_xbar_pkg::data_t   [periph_xbar_pkg::N_OUPS-1:0] out_r_rdata_i,
  input  wire periph_xbar_pkg::inp_id_t [periph_xbar_pkg::N_OUPS-1:0] out_r_id_i,
  input  wire logic [periph_xbar_pkg::N_OUPS-1:0]                     out_r_opc_i,
  output logic [periph_xbar_pkg::N_INPS-1:0]                          in_r_valid_o,
  output periph_xbar_pkg::data_t [periph_xbar_pkg::N_INPS-1:0]        in_r_rdata_o,
  output logic [periph_xbar_pkg::N_INPS-1:0]                          in_r_opc_o
);

  // each initiator takes the target whose response id carries its bit
  // targets never answer the same initiator in one cycle
  always_comb begin
    in_r_valid_o = '0;
    in_r_rdata_o = '0;
    in_r_opc_o   = '0;
    for (int unsigned i = 0; i < periph_xbar_pkg::N_INPS; i++) begin
      for (int unsigned j = 0; j < periph_xbar_pkg::N_OUPS; j++) begin
        if (out_r_valid_i[j] && out_r_id_i[j][i]) begin
          in_r_valid_o[i] = 1'b1;
          in_r_rdata_o[i] = out_r_rdata_i[j];
          in_r_opc_o[i]   = out_r_opc_i[j];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/periph_rr_arbiter.sv
`default_nettype none

module periph_rr_arbiter (
  input  wire logic                                                  clk_i,
  input  wire logic                                                  rst_n_i,
  xbar_req_if.arbiter                                                req_bus,
  output logic [periph_xbar_pkg::N_OUPS-1:0]                         out_req_o,
  output periph_xbar_pkg::addr_t   [periph_xbar_pkg::N_OUPS-1:0]     out_addr_o,
  output periph_xbar_pkg::data_t   [periph_xbar_pkg::N_OUPS-1:0]     out_wdata_o,
  output logic [periph_xbar_pkg::N_OUPS-1:0]                         out_wen_o,
  output periph_xbar_pkg::be_t     [periph_xbar_pkg::N_OUPS-1:0]     out_be_o,
  output periph_xbar_pkg::inp_id_t [periph_xbar_pkg::N_OUPS-1:0]     out_id_o,
  input  wire logic [periph_xbar_pkg::N_OUPS-1:0]                    out_gnt_i
);

  // first requester at or after ptr, walking the initiators cyclically
  function automatic periph_xbar_pkg::inp_id_t rr_pick(
    input logic [periph_xbar_pkg::N_INPS-1:0] reqs,
    input periph_xbar_pkg::inp_idx_t          ptr
  );
    periph_xbar_pkg::inp_id_t pick;
    int unsigned              k;
    logic                     found;
    pick  = '0;
    found = 1'b0;
    for (int unsigned off = 0; off < periph_xbar_pkg::N_INPS; off++) begin
      k = (ptr + off) % periph_xbar_pkg::N_INPS;
      if (!found && reqs[k]) begin
        pick[k] = 1'b1;
        found   = 1'b1;
      end
    end
    return pick;
  endfunction

  for (genvar j = 0; j < periph_xbar_pkg::N_OUPS; j++) begin : gen_oup
    logic [periph_xbar_pkg::N_INPS-1:0] reqs;
    periph_xbar_pkg::inp_id_t           win;
    periph_xbar_pkg::inp_idx_t          ptr_q;
    periph_xbar_pkg::inp_idx_t          ptr_nxt;
    periph_xbar_pkg::addr_t             addr;
    periph_xbar_pkg::data_t             wdata;
    logic                               wen;
    periph_xbar_pkg::be_t               be;

    for (genvar k = 0; k < periph_xbar_pkg::N_INPS; k++) begin : gen_inp
      assign reqs[k] = req_bus.req[k][j];
      // grant only reaches the initiator once the target accepts
      assign req_bus.gnt[k][j] = win[k] & out_gnt_i[j];
    end

    assign win = rr_pick(reqs, ptr_q);

    // payload mux driven by the one-hot winner
    always_comb begin
      ptr_nxt = ptr_q;
      addr    = '0;
      wdata   = '0;
      wen     = 1'b0;
      be      = '0;
      for (int unsigned k = 0; k < periph_xbar_pkg::N_INPS; k++) begin
        if (win[k]) begin
          addr    = req_bus.addr[k];
          wdata   = req_bus.wdata[k];
          wen     = req_bus.wen[k];
          be      = req_bus.be[k];
          ptr_nxt = periph_xbar_pkg::inp_idx_t'((k + 1) % periph_xbar_pkg::N_INPS);
        end
      end
    end

    // pointer moves past the winner only on a completed transfer
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        ptr_q <= '0;
      end else if (out_req_o[j] && out_gnt_i[j]) begin
        ptr_q <= ptr_nxt;
      end
    end

    assign out_req_o[j]   = |reqs;
    assign out_addr_o[j]  = addr;
    assign out_wdata_o[j] = wdata;
    assign out_wen_o[j]   = wen;
    assign out_be_o[j]    = be;
    assign out_id_o[j]    = win;
  end

endmodule

`default_nettype wire

//--- verilog/periph_addr_decode.sv
`default_nettype none

module periph_addr_decode (
  input  wire periph_xbar_pkg::cluster_id_t                         cluster_id_i,
  input  wire logic [periph_xbar_pkg::N_INPS-1:0]                   in_req_i,
  input  wire periph_xbar_pkg::addr_t [periph_xbar_pkg::N_INPS-1:0] in_addr_i,
  input  wire periph_xbar_pkg::data_t [periph_xbar_pkg::N_INPS-1:0] in_wdata_i,
  input  wire logic [periph_xbar_pkg::N_INPS-1:0]                   in_wen_i,
  input  wire periph_xbar_pkg::be_t   [periph_xbar_pkg::N_INPS-1:0] in_be_i,
  output logic [periph_xbar_pkg::N_INPS-1:0]                        in_gnt_o,
  xbar_req_if.decode                                                req_bus
);

  // map an address to its target port
  // is_local is set for the cores of this cluster
  function automatic periph_xbar_pkg::oup_idx_t addr_to_idx(
    input periph_xbar_pkg::addr_t       addr,
    input periph_xbar_pkg::cluster_id_t cid,
    input logic                         is_local
  );
    logic [11:0]               win_lo;
    logic [11:0]               win_hi;
    logic                      in_periph;
    logic                      other_cluster;
    periph_xbar_pkg::oup_idx_t idx;
    win_lo = periph_xbar_pkg::CLUSTER_BASE + {6'b0, cid} * periph_xbar_pkg::CLUSTER_STEP;
    win_hi = win_lo + periph_xbar_pkg::CLUSTER_STEP;
    in_periph = (addr[23:20] >= periph_xbar_pkg::PERIPH_LO) &&
                (addr[23:20] <= periph_xbar_pkg::PERIPH_HI);
    // inside the cluster range but not in our own slot
    other_cluster = is_local &&
                    ((addr[31:20] < win_lo) || (addr[31:20] >= win_hi)) &&
                    (addr[31:20] >= periph_xbar_pkg::CLUSTER_BASE) &&
                    (addr[31:20] < periph_xbar_pkg::CLUSTER_LIMIT);
    if (other_cluster && in_periph) begin
      idx = periph_xbar_pkg::OUP_EXT;
    end else if (((addr[31:24] == periph_xbar_pkg::LOCAL_TOP) || !is_local) && in_periph) begin
      idx = addr[periph_xbar_pkg::ROUTING_MSB:periph_xbar_pkg::ROUTING_LSB];
    end else begin
      // everything else leaves through the SoC port
      idx = periph_xbar_pkg::OUP_EXT;
    end
    return idx;
  endfunction

  // payload is shared by all targets, only the request is steered
  assign req_bus.addr  = in_addr_i;
  assign req_bus.wdata = in_wdata_i;
  assign req_bus.wen   = in_wen_i;
  assign req_bus.be    = in_be_i;

  for (genvar i = 0; i < periph_xbar_pkg::N_INPS; i++) begin : gen_inp
    periph_xbar_pkg::oup_idx_t idx;

    assign idx = addr_to_idx(in_addr_i[i], cluster_id_i, i < periph_xbar_pkg::N_CORES);

    for (genvar j = 0; j < periph_xbar_pkg::N_OUPS; j++) begin : gen_oup
      assign req_bus.req[i][j] = in_req_i[i] && (idx == periph_xbar_pkg::oup_idx_t'(j));
    end

    // at most one target grants this initiator
    assign in_gnt_o[i] = |req_bus.gnt[i];
  end

endmodule

`default_nettype wire

//--- verilog/xbar_req_if.sv
`default_nettype none

interface xbar_req_if;

  // bit [i][j] set when initiator i asks target j
  logic [periph_xbar_pkg::N_INPS-1:0][periph_xbar_pkg::N_OUPS-1:0] req;
  logic [periph_xbar_pkg::N_INPS-1:0][periph_xbar_pkg::N_OUPS-1:0] gnt;

  // request payload, one entry per initiator
  periph_xbar_pkg::addr_t [periph_xbar_pkg::N_INPS-1:0] addr;
  periph_xbar_pkg::data_t [periph_xbar_pkg::N_INPS-1:0] wdata;
  logic                   [periph_xbar_pkg::N_INPS-1:0] wen;
  periph_xbar_pkg::be_t   [periph_xbar_pkg::N_INPS-1:0] be;

  modport decode (
    output req,
    output addr,
    output wdata,
    output wen,
    output be,
    input  gnt
  );

  modport arbiter (
    input  req,
    input  addr,
    input  wdata,
    input  wen,
    input  be,
    output gnt
  );

endinterface

`default_nettype wire

//--- verilog/periph_xbar_pkg.sv
`default_nettype none

package periph_xbar_pkg;

  // crossbar sizes
  localparam int unsigned N_CORES    = 2;
  localparam int unsigned N_MPERIPHS = 1;
  localparam int unsigned N_INPS     = N_CORES + N_MPERIPHS;
  localparam int unsigned N_OUPS     = 4;

  // target 3 leads out to the SoC bus
  localparam logic [1:0] OUP_EXT = 2'd3;

  // routing field inside the peripheral window
  localparam int unsigned ROUTING_LSB = 16;
  localparam int unsigned ROUTING_MSB = 17;

  // cluster address map on bits 31:20, must track the SoC bus map
  localparam logic [11:0] CLUSTER_BASE  = 12'h100;
  localparam logic [11:0] CLUSTER_STEP  = 12'h004;
  localparam logic [11:0] CLUSTER_LIMIT = 12'h1A0;

  // top byte of the local cluster alias
  localparam logic [7:0] LOCAL_TOP = 8'h10;

  // peripheral window on bits 23:20
  localparam logic [3:0] PERIPH_LO = 4'd2;
  localparam logic [3:0] PERIPH_HI = 4'd3;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  typedef logic [1:0]  oup_idx_t;
  // binary initiator index, used by the round-robin pointers
  typedef logic [1:0]  inp_idx_t;
  // one bit per initiator
  typedef logic [2:0]  inp_id_t;
  typedef logic [5:0]  cluster_id_t;

endpackage

`default_nettype wire
